//--- rtl/soc_pkg.sv
package soc_pkg;

    // AHB transfer type encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_ROM  = 2'd1,
        SEL_SRAM = 2'd2
    } slave_sel_e;

    typedef enum logic [2:0] {
        DMA_IDLE    = 3'd0,
        DMA_RD_ADDR = 3'd1,
        DMA_RD_DATA = 3'd2,
        DMA_WR_ADDR = 3'd3,
        DMA_WR_DATA = 3'd4,
        DMA_DONE    = 3'd5
    } dma_state_e;

    // One master's request, hwdata belongs to the following data phase
    typedef struct packed {
        logic [31:0] haddr;
        htrans_e     htrans;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

    // Address map
    localparam logic [31:0] ROM_BASE    = 32'h0000_0000;
    localparam logic [31:0] SRAM_BASE   = 32'h1000_0000;
    localparam logic [31:0] REGION_SIZE = 32'h0000_1000;

    localparam logic [15:0] ROM_TAG = 16'hC0DE;

    // ROM content: tag in the upper half, word index in the lower half
    function automatic logic [31:0] rom_word(input logic [15:0] index);
        return {ROM_TAG, index};
    endfunction

endpackage

//--- rtl/ahb_arbiter.sv
`timescale 1ns/1ps

module ahb_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::ahb_req_t cpu_req,
    input  soc_pkg::ahb_req_t dma_req,
    input  soc_pkg::ahb_rsp_t bus_rsp,
    output soc_pkg::ahb_req_t bus_req,
    output soc_pkg::ahb_rsp_t cpu_rsp,
    output soc_pkg::ahb_rsp_t dma_rsp
);
    import soc_pkg::*;

    logic grant_dma;
    logic data_valid;
    logic data_dma;
    logic cpu_nonseq;
    logic dma_nonseq;

    assign cpu_nonseq = (cpu_req.htrans == NONSEQ);
    assign dma_nonseq = (dma_req.htrans == NONSEQ);

    // Grant and data-phase owner only move when the bus is ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_dma  <= 1'b0;
            data_valid <= 1'b0;
            data_dma   <= 1'b0;
        end else if (bus_rsp.hready) begin
            data_valid <= (bus_req.htrans == NONSEQ);
            data_dma   <= grant_dma;
            // CPU wins, idle bus parks on the CPU
            grant_dma  <= !cpu_nonseq && dma_nonseq;
        end
    end

    always_comb begin
        bus_req        = grant_dma ? dma_req : cpu_req;
        bus_req.hwdata = data_dma ? dma_req.hwdata : cpu_req.hwdata;
    end

    always_comb begin
        cpu_rsp.hrdata = (data_valid && !data_dma) ? bus_rsp.hrdata : '0;
        cpu_rsp.hresp  = data_valid && !data_dma && bus_rsp.hresp;
        // Hold off a waiting master until its address is on the bus
        cpu_rsp.hready = bus_rsp.hready && !(grant_dma && cpu_nonseq);

        dma_rsp.hrdata = (data_valid && data_dma) ? bus_rsp.hrdata : '0;
        dma_rsp.hresp  = data_valid && data_dma && bus_rsp.hresp;
        dma_rsp.hready = bus_rsp.hready && !(!grant_dma && dma_nonseq);
    end

    // An accepted transfer must make that master the data-phase owner
    a_cpu_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_nonseq && cpu_rsp.hready) |=> (data_valid && !data_dma));
    a_dma_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (dma_nonseq && dma_rsp.hready) |=> (data_valid && data_dma));

endmodule

//--- rtl/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder #(
    parameter int ROM_WORDS  = 1024,
    parameter int SRAM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::ahb_req_t bus_req,
    input  soc_pkg::ahb_rsp_t rom_rsp,
    input  soc_pkg::ahb_rsp_t sram_rsp,
    output logic              rom_hsel,
    output logic              sram_hsel,
    output soc_pkg::ahb_rsp_t bus_rsp
);
    import soc_pkg::*;

    // Each region is limited by its window and by the memory depth
    localparam logic [31:0] ROM_SPAN =
        (32'(ROM_WORDS) * 4 < REGION_SIZE) ? 32'(ROM_WORDS) * 4 : REGION_SIZE;
    localparam logic [31:0] SRAM_SPAN =
        (32'(SRAM_WORDS) * 4 < REGION_SIZE) ? 32'(SRAM_WORDS) * 4 : REGION_SIZE;

    slave_sel_e  addr_sel;
    slave_sel_e  data_sel;
    logic [31:0] rom_off;
    logic [31:0] sram_off;
    logic        err_first;
    logic        err_second;
    ahb_rsp_t    def_rsp;

    always_comb begin
        rom_off  = bus_req.haddr - ROM_BASE;
        sram_off = bus_req.haddr - SRAM_BASE;
        if (rom_off < ROM_SPAN) begin
            addr_sel = SEL_ROM;
        end else if (sram_off < SRAM_SPAN) begin
            addr_sel = SEL_SRAM;
        end else begin
            addr_sel = SEL_NONE;
        end
    end

    // Select qualified by the bus being ready, so a stalled address is not taken
    assign rom_hsel  = (addr_sel == SEL_ROM) && bus_rsp.hready;
    assign sram_hsel = (addr_sel == SEL_SRAM) && bus_rsp.hready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sel   <= SEL_NONE;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_first  <= bus_rsp.hready && (bus_req.htrans == NONSEQ) &&
                          (addr_sel == SEL_NONE);
            err_second <= err_first;
            if (bus_rsp.hready) begin
                data_sel <= (bus_req.htrans == NONSEQ) ? addr_sel : SEL_NONE;
            end
        end
    end

    // Default slave, two-cycle ERROR for unmapped accesses
    assign def_rsp.hrdata = '0;
    assign def_rsp.hready = !err_first;
    assign def_rsp.hresp  = err_first || err_second;

    always_comb begin
        case (data_sel)
            SEL_ROM:  bus_rsp = rom_rsp;
            SEL_SRAM: bus_rsp = sram_rsp;
            default:  bus_rsp = def_rsp;
        endcase
    end

    a_hsel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rom_hsel, sram_hsel}));

endmodule

//--- rtl/ahb_sram.sv
`timescale 1ns/1ps

module ahb_sram #(
    parameter int SRAM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hsel,
    input  soc_pkg::ahb_req_t bus_req,
    output soc_pkg::ahb_rsp_t rsp
);
    import soc_pkg::*;

    localparam int AW = $clog2(SRAM_WORDS);

    logic [31:0]   mem [SRAM_WORDS];
    logic [AW-1:0] idx;
    logic [AW-1:0] wr_idx;
    logic          wr_pend;
    logic          start;
    logic [31:0]   rdata_q;

    assign idx   = bus_req.haddr[AW+1:2];
    assign start = hsel && (bus_req.htrans == NONSEQ);

    // Write waits for hwdata in the data phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= start && bus_req.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (start && bus_req.hwrite) begin
            wr_idx <= idx;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_pend) begin
            mem[wr_idx] <= bus_req.hwdata;
        end
        if (start && !bus_req.hwrite) begin
            // Forward a write that completes on the same edge
            if (wr_pend && (wr_idx == idx)) begin
                rdata_q <= bus_req.hwdata;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    // Zero wait states, never an error
    assign rsp.hrdata = rdata_q;
    assign rsp.hready = 1'b1;
    assign rsp.hresp  = 1'b0;

endmodule

//--- rtl/ahb_rom.sv
`timescale 1ns/1ps

module ahb_rom #(
    parameter int ROM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hsel,
    input  soc_pkg::ahb_req_t bus_req,
    output soc_pkg::ahb_rsp_t rsp
);
    import soc_pkg::*;

    localparam int AW = $clog2(ROM_WORDS);

    typedef enum logic [2:0] {
        ROM_IDLE,
        ROM_WAIT,
        ROM_DATA,
        ROM_ERR1,
        ROM_ERR2
    } rom_state_e;

    rom_state_e    state;
    logic [AW-1:0] index_q;
    logic          start;

    assign start = hsel && (bus_req.htrans == NONSEQ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ROM_IDLE;
        end else begin
            case (state)
                ROM_WAIT: state <= ROM_DATA;
                ROM_ERR1: state <= ROM_ERR2;
                // Idle, last data cycle or last error cycle can take a new address
                default: begin
                    if (start) begin
                        state <= bus_req.hwrite ? ROM_ERR1 : ROM_WAIT;
                    end else begin
                        state <= ROM_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            index_q <= bus_req.haddr[AW+1:2];
        end
    end

    assign rsp.hrdata = (state == ROM_DATA) ? rom_word(16'(index_q)) : '0;
    assign rsp.hready = (state != ROM_WAIT) && (state != ROM_ERR1);
    assign rsp.hresp  = (state == ROM_ERR1) || (state == ROM_ERR2);

    // An error always opens with a wait cycle
    a_err_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.hresp |-> ($past(rsp.hresp) || !rsp.hready));

endmodule

//--- rtl/dma_engine.sv
`timescale 1ns/1ps

module dma_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dma_start,
    input  logic [31:0]       dma_src_addr,
    input  logic [31:0]       dma_dest_addr,
    input  logic [15:0]       dma_transfer_size,
    input  soc_pkg::ahb_rsp_t dma_rsp,
    output logic              dma_done,
    output logic              dma_busy,
    output soc_pkg::ahb_req_t dma_req
);
    import soc_pkg::*;

    dma_state_e  state;
    logic [31:0] src_q;
    logic [31:0] dest_q;
    logic [15:0] count_q;
    logic [31:0] data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= DMA_IDLE;
            count_q <= '0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (dma_start) begin
                        count_q <= dma_transfer_size;
                        // Nothing to move, finish straight away
                        state   <= (dma_transfer_size == '0) ? DMA_DONE : DMA_RD_ADDR;
                    end
                end
                DMA_RD_ADDR: begin
                    if (dma_rsp.hready) begin
                        state <= DMA_RD_DATA;
                    end
                end
                DMA_RD_DATA: begin
                    if (dma_rsp.hready) begin
                        state <= dma_rsp.hresp ? DMA_DONE : DMA_WR_ADDR;
                    end
                end
                DMA_WR_ADDR: begin
                    if (dma_rsp.hready) begin
                        state <= DMA_WR_DATA;
                    end
                end
                DMA_WR_DATA: begin
                    if (dma_rsp.hready) begin
                        count_q <= count_q - 16'd1;
                        if (dma_rsp.hresp || (count_q == 16'd1)) begin
                            state <= DMA_DONE;
                        end else begin
                            state <= DMA_RD_ADDR;
                        end
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    // Address and data registers
    always_ff @(posedge clk) begin
        if (state == DMA_IDLE && dma_start) begin
            src_q  <= dma_src_addr;
            dest_q <= dma_dest_addr;
        end else if (state == DMA_WR_DATA && dma_rsp.hready) begin
            src_q  <= src_q + 32'd4;
            dest_q <= dest_q + 32'd4;
        end
        if (state == DMA_RD_DATA && dma_rsp.hready && !dma_rsp.hresp) begin
            data_q <= dma_rsp.hrdata;
        end
    end

    always_comb begin
        dma_req.hwdata = data_q;
        case (state)
            DMA_RD_ADDR: begin
                dma_req.haddr  = src_q;
                dma_req.htrans = NONSEQ;
                dma_req.hwrite = 1'b0;
            end
            DMA_WR_ADDR: begin
                dma_req.haddr  = dest_q;
                dma_req.htrans = NONSEQ;
                dma_req.hwrite = 1'b1;
            end
            default: begin
                dma_req.haddr  = src_q;
                dma_req.htrans = IDLE;
                dma_req.hwrite = 1'b0;
            end
        endcase
    end

    assign dma_done = (state == DMA_DONE);
    assign dma_busy = (state != DMA_IDLE) && (state != DMA_DONE);

endmodule

//--- rtl/soc_fabric.sv
`timescale 1ns/1ps

module soc_fabric #(
    parameter int ROM_WORDS  = 1024,
    parameter int SRAM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::ahb_req_t cpu_req,
    input  logic              dma_start,
    input  logic [31:0]       dma_src_addr,
    input  logic [31:0]       dma_dest_addr,
    input  logic [15:0]       dma_transfer_size,
    output soc_pkg::ahb_rsp_t cpu_rsp,
    output logic              dma_done,
    output logic              dma_busy
);
    import soc_pkg::*;

    // Master side
    ahb_req_t dma_req;
    ahb_rsp_t dma_rsp;

    // Shared bus
    ahb_req_t bus_req;
    ahb_rsp_t bus_rsp;

    // Slave side
    logic     rom_hsel;
    logic     sram_hsel;
    ahb_rsp_t rom_rsp;
    ahb_rsp_t sram_rsp;

    ahb_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .dma_req (dma_req),
        .bus_rsp (bus_rsp),
        .bus_req (bus_req),
        .cpu_rsp (cpu_rsp),
        .dma_rsp (dma_rsp)
    );

    ahb_decoder #(
        .ROM_WORDS  (ROM_WORDS),
        .SRAM_WORDS (SRAM_WORDS)
    ) u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .rom_rsp   (rom_rsp),
        .sram_rsp  (sram_rsp),
        .rom_hsel  (rom_hsel),
        .sram_hsel (sram_hsel),
        .bus_rsp   (bus_rsp)
    );

    ahb_rom #(
        .ROM_WORDS (ROM_WORDS)
    ) u_rom (
        .clk     (clk),
        .rst_n   (rst_n),
        .hsel    (rom_hsel),
        .bus_req (bus_req),
        .rsp     (rom_rsp)
    );

    ahb_sram #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .hsel    (sram_hsel),
        .bus_req (bus_req),
        .rsp     (sram_rsp)
    );

    dma_engine u_dma (
        .clk               (clk),
        .rst_n             (rst_n),
        .dma_start         (dma_start),
        .dma_src_addr      (dma_src_addr),
        .dma_dest_addr     (dma_dest_addr),
        .dma_transfer_size (dma_transfer_size),
        .dma_rsp           (dma_rsp),
        .dma_done          (dma_done),
        .dma_busy          (dma_busy),
        .dma_req           (dma_req)
    );

endmodule

//--- test/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;
    import soc_pkg::*;

    localparam int          CYCLE_LIMIT = 20000;
    localparam logic [31:0] SRAM_ADDR   = 32'h1000_0000;
    localparam logic [31:0] UNMAPPED    = 32'h2000_0000;
    // ROM words carry this tag above their word index
    localparam logic [15:0] TAG         = 16'hC0DE;

    logic        clk = 1'b0;
    logic        rst_n;
    ahb_req_t    cpu_req;
    ahb_rsp_t    cpu_rsp;
    logic        dma_start;
    logic [31:0] dma_src_addr;
    logic [31:0] dma_dest_addr;
    logic [15:0] dma_transfer_size;
    logic        dma_done;
    logic        dma_busy;

    int          cycles     = 0;
    int          done_count = 0;
    int          fail_count = 0;
    logic        done_prev;

    soc_fabric #(
        .ROM_WORDS  (1024),
        .SRAM_WORDS (1024)
    ) dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .cpu_req           (cpu_req),
        .dma_start         (dma_start),
        .dma_src_addr      (dma_src_addr),
        .dma_dest_addr     (dma_dest_addr),
        .dma_transfer_size (dma_transfer_size),
        .cpu_rsp           (cpu_rsp),
        .dma_done          (dma_done),
        .dma_busy          (dma_busy)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string what);
        fail_count++;
        $display("ERROR at %0t: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    // Count finished DMA jobs and watch the single-cycle dma_done
    always @(posedge clk) begin
        if (!rst_n) begin
            done_prev <= 1'b0;
        end else begin
            done_prev <= dma_done;
            if (dma_done) begin
                done_count <= done_count + 1;
                assert (!dma_busy)
                    else report_mismatch("dma_busy still high while dma_done is high");
            end
            assert (!(dma_done && done_prev))
                else report_mismatch("dma_done stayed high for two cycles");
        end
    end

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
            else report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp);
        assert (got === exp)
            else report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    // Single CPU port transfer through its address and data phases
    task automatic bus_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic resp);
        @(posedge clk);
        cpu_req.haddr  <= addr;
        cpu_req.htrans <= NONSEQ;
        cpu_req.hwrite <= write;
        // Taken on the first edge with hready high
        @(negedge clk);
        while (!cpu_rsp.hready) begin
            @(negedge clk);
        end
        @(posedge clk);
        cpu_req.htrans <= IDLE;
        cpu_req.hwdata <= wdata;
        @(negedge clk);
        while (!cpu_rsp.hready) begin
            @(negedge clk);
        end
        rdata = cpu_rsp.hrdata;
        resp  = cpu_rsp.hresp;
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic resp);
        logic [31:0] unused_rdata;
        bus_transfer(addr, 1'b1, data, unused_rdata, resp);
    endtask

    task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic resp);
        bus_transfer(addr, 1'b0, 32'h0, data, resp);
    endtask

    task automatic start_dma(input logic [31:0] src, input logic [31:0] dest,
                             input logic [15:0] size);
        @(posedge clk);
        dma_src_addr      <= src;
        dma_dest_addr     <= dest;
        dma_transfer_size <= size;
        dma_start         <= 1'b1;
        @(posedge clk);
        dma_start <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_dma_done(input int jobs_before);
        while (done_count == jobs_before) begin
            @(negedge clk);
        end
        expect_bit("dma_busy after dma_done", dma_busy, 1'b0);
    endtask

    task automatic sram_write_readback();
        logic [31:0] data [16];
        logic [31:0] got;
        logic        resp;
        int          i;
        for (i = 0; i < 16; i++) begin
            data[i] = $urandom;
            cpu_write(SRAM_ADDR + 32'(i * 4), data[i], resp);
            expect_bit("SRAM write hresp", resp, 1'b0);
        end
        for (i = 0; i < 16; i++) begin
            cpu_read(SRAM_ADDR + 32'(i * 4), got, resp);
            expect_bit("SRAM read hresp", resp, 1'b0);
            expect_word("SRAM readback", got, data[i]);
        end
    endtask

    task automatic rom_pattern_read();
        int          idx [6] = '{0, 1, 7, 100, 511, 1023};
        logic [31:0] got;
        logic        resp;
        int          i;
        for (i = 0; i < 6; i++) begin
            cpu_read(32'(idx[i] * 4), got, resp);
            expect_bit("ROM read hresp", resp, 1'b0);
            expect_word("ROM word", got, {TAG, 16'(idx[i])});
        end
    endtask

    task automatic error_responses();
        logic [31:0] got;
        logic        resp;
        cpu_write(32'h0000_0010, 32'h1234_5678, resp);
        expect_bit("ROM write hresp", resp, 1'b1);
        cpu_read(UNMAPPED, got, resp);
        expect_bit("Unmapped read hresp", resp, 1'b1);
        // Just past the end of the SRAM window
        cpu_read(SRAM_ADDR + 32'h1000, got, resp);
        expect_bit("Read past SRAM hresp", resp, 1'b1);
        cpu_write(SRAM_ADDR + 32'hFFC, 32'hA5A5_5A5A, resp);
        expect_bit("SRAM write after error", resp, 1'b0);
        cpu_read(SRAM_ADDR + 32'hFFC, got, resp);
        expect_bit("SRAM read after error", resp, 1'b0);
        expect_word("SRAM data after error", got, 32'hA5A5_5A5A);
    endtask

    task automatic dma_rom_to_sram();
        logic [31:0] got;
        logic        resp;
        int          jobs;
        int          i;
        jobs = done_count;
        start_dma(32'd8 * 4, SRAM_ADDR + 32'h200, 16'd32);
        expect_bit("dma_busy after start", dma_busy, 1'b1);
        wait_dma_done(jobs);
        for (i = 0; i < 32; i++) begin
            cpu_read(SRAM_ADDR + 32'h200 + 32'(i * 4), got, resp);
            expect_bit("DMA copy read hresp", resp, 1'b0);
            expect_word("DMA copy of ROM", got, {TAG, 16'(8 + i)});
        end
    endtask

    task automatic dma_with_cpu_traffic();
        logic [31:0] src [16];
        logic [31:0] word;
        logic [31:0] got;
        logic        resp;
        int          jobs;
        int          overlap;
        int          i;
        overlap = 0;
        for (i = 0; i < 16; i++) begin
            src[i] = $urandom;
            cpu_write(SRAM_ADDR + 32'h400 + 32'(i * 4), src[i], resp);
        end
        jobs = done_count;
        start_dma(SRAM_ADDR + 32'h400, SRAM_ADDR + 32'h600, 16'd16);
        // CPU works in its own window while the copy runs
        for (i = 0; i < 12; i++) begin
            if (dma_busy) begin
                overlap++;
            end
            word = $urandom;
            cpu_write(SRAM_ADDR + 32'h800 + 32'(i * 4), word, resp);
            expect_bit("CPU write during DMA hresp", resp, 1'b0);
            cpu_read(SRAM_ADDR + 32'h800 + 32'(i * 4), got, resp);
            expect_bit("CPU read during DMA hresp", resp, 1'b0);
            expect_word("CPU read during DMA", got, word);
        end
        expect_bit("CPU traffic overlapped the DMA", overlap > 0, 1'b1);
        wait_dma_done(jobs);
        for (i = 0; i < 16; i++) begin
            cpu_read(SRAM_ADDR + 32'h600 + 32'(i * 4), got, resp);
            expect_word("DMA SRAM copy", got, src[i]);
        end
    endtask

    task automatic dma_unmapped_source();
        logic [31:0] got;
        logic        resp;
        int          jobs;
        int          i;
        jobs = done_count;
        start_dma(UNMAPPED, SRAM_ADDR + 32'h200, 16'd4);
        wait_dma_done(jobs);
        // Destination still holds the earlier ROM copy
        for (i = 0; i < 4; i++) begin
            cpu_read(SRAM_ADDR + 32'h200 + 32'(i * 4), got, resp);
            expect_word("Destination after failed DMA", got, {TAG, 16'(8 + i)});
        end
        jobs = done_count;
        start_dma(SRAM_ADDR, SRAM_ADDR + 32'h200, 16'd0);
        wait_dma_done(jobs);
    endtask

    initial begin
        void'($urandom(32'h8119));
        rst_n             <= 1'b0;
        cpu_req           <= '0;
        dma_start         <= 1'b0;
        dma_src_addr      <= '0;
        dma_dest_addr     <= '0;
        dma_transfer_size <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_bit("hready after reset", cpu_rsp.hready, 1'b1);
        expect_bit("hresp after reset", cpu_rsp.hresp, 1'b0);
        expect_bit("dma_done after reset", dma_done, 1'b0);
        expect_bit("dma_busy after reset", dma_busy, 1'b0);

        sram_write_readback();
        rom_pattern_read();
        error_responses();
        dma_rom_to_sram();
        dma_with_cpu_traffic();
        dma_unmapped_source();

        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/soc_pkg.sv
rtl/ahb_arbiter.sv
rtl/ahb_decoder.sv
rtl/ahb_sram.sv
rtl/ahb_rom.sv
rtl/dma_engine.sv
rtl/soc_fabric.sv
test/tb_soc.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f list.f -o tb_soc_sim \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/tb_soc_sim 2>&1)
echo "$out"
echo "$out" | grep -qF '>>> PASS' \
    && echo "Simulation result: passed" \
    || { echo "Simulation result: failed"; exit 1; }
